// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_conv_ctrl
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
PASS_MSG ?= ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: conv_ctrl_pkg.sv
package conv_ctrl_pkg;

    // data and address widths
    typedef logic [7:0] pixel_t;
    typedef logic [5:0] mem_addr_t;

    typedef struct packed {
        mem_addr_t addr;
        pixel_t    wdata;
        logic      we;
    } mem_req_t;

    localparam int IMAGE_SIZE         = 4;
    localparam int KERNEL_SIZE        = 3;
    localparam int OPERAND_COUNT      = 25;
    localparam int ENGINE_COUNT       = 3;
    localparam int RESULTS_PER_ENGINE = 4;

    // operand registers, row-major
    typedef pixel_t [IMAGE_SIZE-1:0][IMAGE_SIZE-1:0]   image_t;
    typedef pixel_t [KERNEL_SIZE-1:0][KERNEL_SIZE-1:0] kernel_t;

    typedef struct packed {
        logic   result_valid;
        logic   done;
        pixel_t result;
    } engine_rsp_t;

    localparam int ENG_PE = 0;
    localparam int ENG_SA = 1;
    localparam int ENG_CT = 2;

    // parked address when the RAM is not accessed
    localparam mem_addr_t MEM_IDLE_ADDR = 6'd25;

    localparam mem_addr_t RESULT_BASE [ENGINE_COUNT] = '{6'd32, 6'd37, 6'd42};

    // image at 0..15, kernel at 16..24
    localparam pixel_t OPERAND_TABLE [OPERAND_COUNT] = '{
        8'd233, 8'd123, 8'd12,  8'd3,
        8'd5,   8'd2,   8'd3,   8'd3,
        8'd9,   8'd255, 8'd1,   8'd12,
        8'd13,  8'd64,  8'd55,  8'd27,
        8'd13,  8'd2,   8'd3,
        8'd2,   8'd1,   8'd50,
        8'd51,  8'd52,  8'd1
    };

    // sa hands its results back as c21, c11, c22, c12
    localparam mem_addr_t SLOT_ORDER [ENGINE_COUNT][RESULTS_PER_ENGINE] = '{
        '{6'd0, 6'd1, 6'd2, 6'd3},
        '{6'd2, 6'd0, 6'd3, 6'd1},
        '{6'd0, 6'd1, 6'd2, 6'd3}
    };

endpackage

// File: conv_ctrl_top.sv
module conv_ctrl_top (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    start,
    input  conv_ctrl_pkg::pixel_t                   q,
    input  conv_ctrl_pkg::engine_rsp_t              engine_rsp [conv_ctrl_pkg::ENGINE_COUNT],
    output conv_ctrl_pkg::mem_req_t                 mem,
    output conv_ctrl_pkg::image_t                   image,
    output conv_ctrl_pkg::kernel_t                  kernel,
    output logic [conv_ctrl_pkg::ENGINE_COUNT-1:0]  engine_start,
    output logic                                    all_done
);

    conv_ctrl_pkg::mem_req_t loader_mem;
    logic                    operands_ready;

    // writes and reads back the operands
    operand_store operand_store_i (
        .clk            (clk),
        .reset          (reset),
        .start          (start),
        .q              (q),
        .loader_mem     (loader_mem),
        .image          (image),
        .kernel         (kernel),
        .operands_ready (operands_ready)
    );

    // runs pe, sa and ct and stores their results
    engine_sequencer engine_sequencer_i (
        .clk            (clk),
        .reset          (reset),
        .operands_ready (operands_ready),
        .loader_mem     (loader_mem),
        .engine_rsp     (engine_rsp),
        .engine_start   (engine_start),
        .mem            (mem),
        .all_done       (all_done)
    );

endmodule

// File: engine_sequencer.sv
module engine_sequencer (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    operands_ready,
    input  conv_ctrl_pkg::mem_req_t                 loader_mem,
    input  conv_ctrl_pkg::engine_rsp_t              engine_rsp [conv_ctrl_pkg::ENGINE_COUNT],
    output logic [conv_ctrl_pkg::ENGINE_COUNT-1:0]  engine_start,
    output conv_ctrl_pkg::mem_req_t                 mem,
    output logic                                    all_done
);

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_STARTING,
        SEQ_COLLECTING,
        SEQ_AWAIT_DONE,
        SEQ_DONE
    } seq_phase_t;

    typedef logic [$clog2(conv_ctrl_pkg::ENGINE_COUNT)-1:0]       engine_idx_t;
    typedef logic [$clog2(conv_ctrl_pkg::RESULTS_PER_ENGINE)-1:0] result_idx_t;

    seq_phase_t                 phase;
    engine_idx_t                eng;
    result_idx_t                result_cnt;
    conv_ctrl_pkg::engine_rsp_t active_rsp;
    logic                       last_result;
    logic                       last_engine;
    logic                       result_write;

    // strobes of inactive engines never reach the FSM
    assign active_rsp   = engine_rsp[eng];
    assign last_result  = (result_cnt == result_idx_t'(conv_ctrl_pkg::RESULTS_PER_ENGINE - 1));
    assign last_engine  = (eng == engine_idx_t'(conv_ctrl_pkg::ENG_CT));
    assign result_write = (phase == SEQ_COLLECTING) && active_rsp.result_valid;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase      <= SEQ_IDLE;
            eng        <= engine_idx_t'(conv_ctrl_pkg::ENG_PE);
            result_cnt <= '0;
        end else begin
            case (phase)
                SEQ_IDLE: begin
                    if (operands_ready) begin
                        phase <= SEQ_STARTING;
                        eng   <= engine_idx_t'(conv_ctrl_pkg::ENG_PE);
                    end
                end
                SEQ_STARTING: begin
                    phase      <= SEQ_COLLECTING;
                    result_cnt <= '0;
                end
                SEQ_COLLECTING: begin
                    if (active_rsp.result_valid) begin
                        result_cnt <= result_cnt + 1'b1;
                        if (last_result) begin
                            phase <= SEQ_AWAIT_DONE;
                        end
                    end
                end
                SEQ_AWAIT_DONE: begin
                    if (active_rsp.done) begin
                        if (last_engine) begin
                            phase <= SEQ_DONE;
                        end else begin
                            eng   <= eng + 1'b1;
                            phase <= SEQ_STARTING;
                        end
                    end
                end
                SEQ_DONE: begin
                    // held until reset
                    phase <= SEQ_DONE;
                end
                default: begin
                    phase <= SEQ_IDLE;
                end
            endcase
        end
    end

    always_comb begin
        engine_start = '0;
        if (phase == SEQ_STARTING) begin
            engine_start[eng] = 1'b1;
        end
    end

    assign all_done = (phase == SEQ_DONE);

    // RAM port belongs to the operand store until the engines run
    always_comb begin
        if (phase == SEQ_IDLE) begin
            mem = loader_mem;
        end else begin
            mem.addr  = conv_ctrl_pkg::MEM_IDLE_ADDR;
            mem.wdata = '0;
            mem.we    = 1'b0;
            if (result_write) begin
                mem.addr  = conv_ctrl_pkg::RESULT_BASE[eng] +
                            conv_ctrl_pkg::SLOT_ORDER[eng][result_cnt];
                mem.wdata = active_rsp.result;
                mem.we    = 1'b1;
            end
        end
    end

    // a start pulse must select exactly one existing engine
    a_start_onehot: assert property (
        @(posedge clk) disable iff (reset)
        (phase == SEQ_STARTING) |-> $onehot(engine_start)
    ) else $error("engine start not one-hot while starting: %b", engine_start);

    a_result_in_result_area: assert property (
        @(posedge clk) disable iff (reset)
        (phase != SEQ_IDLE && mem.we) |->
            (mem.addr >= conv_ctrl_pkg::RESULT_BASE[conv_ctrl_pkg::ENG_PE])
    ) else $error("result write below result area at addr %0d", mem.addr);

endmodule

// File: operand_store.sv
module operand_store (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  conv_ctrl_pkg::pixel_t   q,
    output conv_ctrl_pkg::mem_req_t loader_mem,
    output conv_ctrl_pkg::image_t   image,
    output conv_ctrl_pkg::kernel_t  kernel,
    output logic                    operands_ready
);

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_WRITE,
        PH_LOAD,
        PH_FINISHED
    } phase_t;

    typedef logic [$clog2(conv_ctrl_pkg::OPERAND_COUNT)-1:0] operand_idx_t;

    phase_t       phase;
    operand_idx_t idx;
    operand_idx_t kernel_idx;
    logic         capture;
    logic         last_operand;
    logic         in_image;

    assign last_operand = (idx == operand_idx_t'(conv_ctrl_pkg::OPERAND_COUNT - 1));
    assign in_image     = (idx < operand_idx_t'(conv_ctrl_pkg::IMAGE_SIZE *
                                                conv_ctrl_pkg::IMAGE_SIZE));
    // kernel words follow the image words
    assign kernel_idx   = idx - operand_idx_t'(conv_ctrl_pkg::IMAGE_SIZE *
                                               conv_ctrl_pkg::IMAGE_SIZE);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase          <= PH_IDLE;
            idx            <= '0;
            capture        <= 1'b0;
            operands_ready <= 1'b0;
        end else begin
            operands_ready <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    if (start) begin
                        phase <= PH_WRITE;
                        idx   <= '0;
                    end
                end
                PH_WRITE: begin
                    if (last_operand) begin
                        phase   <= PH_LOAD;
                        idx     <= '0;
                        capture <= 1'b0;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                PH_LOAD: begin
                    // read cycle, then capture cycle
                    capture <= ~capture;
                    if (capture) begin
                        if (last_operand) begin
                            phase          <= PH_FINISHED;
                            operands_ready <= 1'b1;
                        end else begin
                            idx <= idx + 1'b1;
                        end
                    end
                end
                PH_FINISHED: begin
                    // one run per reset
                    phase <= PH_FINISHED;
                end
                default: begin
                    phase <= PH_IDLE;
                end
            endcase
        end
    end

    always_comb begin
        loader_mem.addr  = conv_ctrl_pkg::MEM_IDLE_ADDR;
        loader_mem.wdata = '0;
        loader_mem.we    = 1'b0;
        case (phase)
            PH_WRITE: begin
                loader_mem.addr  = conv_ctrl_pkg::mem_addr_t'(idx);
                loader_mem.wdata = conv_ctrl_pkg::OPERAND_TABLE[idx];
                loader_mem.we    = 1'b1;
            end
            PH_LOAD: begin
                if (!capture) begin
                    loader_mem.addr = conv_ctrl_pkg::mem_addr_t'(idx);
                end
            end
            default: begin
                loader_mem.we = 1'b0;
            end
        endcase
    end

    // q holds the word read in the previous cycle
    always_ff @(posedge clk) begin
        if (phase == PH_LOAD && capture) begin
            if (in_image) begin
                image[idx / conv_ctrl_pkg::IMAGE_SIZE][idx % conv_ctrl_pkg::IMAGE_SIZE] <= q;
            end else begin
                kernel[kernel_idx / conv_ctrl_pkg::KERNEL_SIZE]
                      [kernel_idx % conv_ctrl_pkg::KERNEL_SIZE] <= q;
            end
        end
    end

    a_write_in_operand_area: assert property (
        @(posedge clk) disable iff (reset)
        loader_mem.we |-> (loader_mem.addr < conv_ctrl_pkg::OPERAND_COUNT)
    ) else $error("operand write outside operand area at addr %0d", loader_mem.addr);

endmodule

// File: tb_conv_ctrl.sv
module tb_conv_ctrl;

    localparam int CLK_PERIOD = 4;
    // reset, operand load, three engines at worst case, restart window
    localparam int TEST_CYCLES = 16 + 75 + 3 * (4 * 4 + 8) + 12;
    localparam int WATCHDOG_TIME = 4 * TEST_CYCLES * CLK_PERIOD;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic start = 1'b0;
    conv_ctrl_pkg::pixel_t q = '0;
    conv_ctrl_pkg::engine_rsp_t engine_rsp [conv_ctrl_pkg::ENGINE_COUNT];
    conv_ctrl_pkg::mem_req_t mem;
    conv_ctrl_pkg::image_t image;
    conv_ctrl_pkg::kernel_t kernel;
    logic [conv_ctrl_pkg::ENGINE_COUNT-1:0] engine_start;
    logic all_done;

    conv_ctrl_pkg::pixel_t ram [64];
    conv_ctrl_pkg::pixel_t exp_ram [64];
    conv_ctrl_pkg::pixel_t read_data = '0;
    logic [31:0] lfsr = 32'h2f37b7b7;
    int write_count = 0;
    int cycle = 0;
    int start_count = 0;
    int done_count = 0;
    int last_done_cycle = 0;
    int checks = 0;
    int errors = 0;

    conv_ctrl_top conv_ctrl_top_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // 64-byte synchronous RAM
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (mem.we) begin
            ram[mem.addr] <= mem.wdata;
            write_count <= write_count + 1;
        end
        read_data <= ram[mem.addr];
    end

    always @(negedge clk) q <= read_data;

    function automatic conv_ctrl_pkg::pixel_t fill_byte(input int a);
        return conv_ctrl_pkg::pixel_t'(a) ^ 8'h5a;
    endfunction

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] bits;
        logic fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    // result areas are 5 bytes apart from 32, sa returns c21 c11 c22 c12
    function automatic conv_ctrl_pkg::mem_addr_t result_addr(input int e, input int k);
        int offset;
        offset = k;
        if (e == conv_ctrl_pkg::ENG_SA) begin
            case (k)
                0: offset = 2;
                1: offset = 0;
                2: offset = 3;
                default: offset = 1;
            endcase
        end
        return conv_ctrl_pkg::mem_addr_t'(32 + 5 * e + offset);
    endfunction

    task automatic note_failure(input string what);
        errors++;
        $display("error at %0t: %s", $time, what);
    endtask

    task automatic compare_pixel(input string name, input conv_ctrl_pkg::pixel_t got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic compare_addr(input string name, input conv_ctrl_pkg::mem_addr_t got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic compare_mem_req(input string name, input conv_ctrl_pkg::mem_req_t got, exp);
        string got_text;
        string exp_text;
        checks++;
        if (got !== exp) begin
            errors++;
            got_text = $sformatf("addr %0d wdata %0d we %b", got.addr, got.wdata, got.we);
            exp_text = $sformatf("addr %0d wdata %0d we %b", exp.addr, exp.wdata, exp.we);
            $display("mismatch at %0t: %s got %s expected %s", $time, name, got_text, exp_text);
        end
    endtask

    task automatic compare_logic(input string name, input logic got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic compare_int(input string name, input int got, exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_idle_outputs(input string when);
        compare_logic({when, " mem.we"}, mem.we, 1'b0);
        compare_addr({when, " mem.addr"}, mem.addr, conv_ctrl_pkg::MEM_IDLE_ADDR);
        compare_logic({when, " all_done"}, all_done, 1'b0);
        for (int e = 0; e < conv_ctrl_pkg::ENGINE_COUNT; e++) begin
            compare_logic($sformatf("%s engine_start[%0d]", when, e), engine_start[e], 1'b0);
        end
    endtask

    // engines start in order, one at a time, a cycle after the previous done
    always @(negedge clk) begin
        #1;
        for (int e = 0; e < conv_ctrl_pkg::ENGINE_COUNT; e++) begin
            if (!reset && engine_start[e]) begin
                if (start_count >= conv_ctrl_pkg::ENGINE_COUNT) begin
                    note_failure($sformatf("engine %0d started after all engines ran", e));
                end else if (done_count != start_count) begin
                    note_failure($sformatf("engine %0d started while another was busy", e));
                end else begin
                    compare_int("started engine", e, start_count);
                    if (start_count > 0) begin
                        compare_int("engine start cycle", cycle, last_done_cycle + 1);
                    end
                end
                start_count++;
            end
        end
    end

    task automatic engine_model(input int e);
        conv_ctrl_pkg::pixel_t value;
        conv_ctrl_pkg::mem_req_t exp_req;
        int gap;
        do begin
            @(negedge clk);
            #1;
        end while (!engine_start[e]);
        for (int k = 0; k < conv_ctrl_pkg::RESULTS_PER_ENGINE; k++) begin
            value = conv_ctrl_pkg::pixel_t'(lfsr_bits(8));
            gap = int'(lfsr_bits(2));
            @(negedge clk);
            engine_rsp[e].result_valid = 1'b1;
            engine_rsp[e].result = value;
            exp_ram[result_addr(e, k)] = value;
            exp_req.addr = result_addr(e, k);
            exp_req.wdata = value;
            exp_req.we = 1'b1;
            #1;
            compare_mem_req($sformatf("mem for engine %0d result %0d", e, k), mem, exp_req);
            repeat (gap) begin
                @(negedge clk);
                engine_rsp[e].result_valid = 1'b0;
            end
        end
        @(negedge clk);
        engine_rsp[e].result_valid = 1'b0;
        engine_rsp[e].done = 1'b1;
        done_count++;
        last_done_cycle = cycle;
        @(negedge clk);
        engine_rsp[e].done = 1'b0;
    endtask

    task automatic write_operands();
        conv_ctrl_pkg::mem_req_t exp_req;
        @(negedge clk);
        start = 1'b1;
        for (int n = 0; n < conv_ctrl_pkg::OPERAND_COUNT; n++) begin
            @(negedge clk);
            start = 1'b0;
            exp_req.addr = conv_ctrl_pkg::mem_addr_t'(n);
            exp_req.wdata = conv_ctrl_pkg::OPERAND_TABLE[n];
            exp_req.we = 1'b1;
            exp_ram[n] = conv_ctrl_pkg::OPERAND_TABLE[n];
            #1;
            compare_mem_req($sformatf("mem during operand write %0d", n), mem, exp_req);
        end
    endtask

    // 50 load cycles, the ready pulse, then the pe start
    task automatic wait_for_pe_start();
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            #1;
            waited++;
        end while (!engine_start[conv_ctrl_pkg::ENG_PE] && waited < 200);
        compare_int("cycles from last operand write to pe start", waited, 52);
        compare_int("RAM writes before pe start", write_count, 25);
        for (int n = 0; n < 16; n++) begin
            compare_pixel($sformatf("image[%0d][%0d]", n / 4, n % 4), image[n / 4][n % 4],
                          conv_ctrl_pkg::OPERAND_TABLE[n]);
        end
        for (int n = 0; n < 9; n++) begin
            compare_pixel($sformatf("kernel[%0d][%0d]", n / 3, n % 3), kernel[n / 3][n % 3],
                          conv_ctrl_pkg::OPERAND_TABLE[16 + n]);
        end
    endtask

    task automatic wait_for_all_done();
        do begin
            @(negedge clk);
            #1;
        end while (!all_done);
        compare_int("engine done count at all_done", done_count, 3);
        compare_int("all_done cycle", cycle, last_done_cycle + 1);
    endtask

    task automatic check_restart_ignored();
        int writes_before;
        int starts_before;
        writes_before = write_count;
        starts_before = start_count;
        @(negedge clk);
        start = 1'b1;
        repeat (10) begin
            @(negedge clk);
            start = 1'b0;
            #1;
            compare_logic("all_done after restart", all_done, 1'b1);
            compare_logic("mem.we after restart", mem.we, 1'b0);
            compare_addr("mem.addr after restart", mem.addr, conv_ctrl_pkg::MEM_IDLE_ADDR);
        end
        compare_int("RAM writes after restart", write_count, writes_before);
        compare_int("engine starts after restart", start_count, starts_before);
    endtask

    task automatic check_ram_contents();
        for (int a = 0; a < 64; a++) begin
            compare_pixel($sformatf("ram[%0d]", a), ram[a], exp_ram[a]);
        end
        compare_int("total RAM writes", write_count, 37);
        compare_int("total engine starts", start_count, 3);
    endtask

    initial begin
        #(WATCHDOG_TIME);
        $display("timeout: all_done and the restart check not finished after %0d cycles", cycle);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        for (int e = 0; e < conv_ctrl_pkg::ENGINE_COUNT; e++) begin
            engine_rsp[e] = '0;
        end
        for (int a = 0; a < 64; a++) begin
            ram[a] <= fill_byte(a);
            exp_ram[a] = fill_byte(a);
        end
        repeat (15) @(negedge clk);
        #1;
        check_idle_outputs("in reset");
        @(negedge clk);
        reset = 1'b0;
        #1;
        check_idle_outputs("after reset");
        fork
            engine_model(conv_ctrl_pkg::ENG_PE);
            engine_model(conv_ctrl_pkg::ENG_SA);
            engine_model(conv_ctrl_pkg::ENG_CT);
        join_none
        write_operands();
        wait_for_pe_start();
        wait_for_all_done();
        check_restart_ignored();
        check_ram_contents();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
conv_ctrl_pkg.sv
operand_store.sv
engine_sequencer.sv
conv_ctrl_top.sv
tb_conv_ctrl.sv
